//--- Bender.yml
package:
  name: alu_exec

sources:
  - alu_cpu_pkg.sv
  - alu_regfile.sv
  - alu_flag_reg.sv
  - alu_core.sv
  - alu_exec_ctrl.sv
  - alu_exec_top.sv
  - target: test
    files:
      - tb_alu_exec.sv

//--- alu_core.sv
/*
 * Combinational 16-bit ALU
 * Saturating ADD/SUB, XOR, RED, shifts, PADDSB, LW/SW address, LLB/LHB
 * Z/V/N candidates and invalid-opcode flag
 */
`timescale 1ns/1ps
`default_nettype none

module alu_core (
  input  alu_cpu_pkg::alu_op_e           op,
  input  logic [alu_cpu_pkg::data_w-1:0] in_a,
  input  logic [alu_cpu_pkg::data_w-1:0] in_b,
  output alu_cpu_pkg::alu_out_t          out
);

  logic [alu_cpu_pkg::data_w-1:0] res;
  logic [alu_cpu_pkg::data_w-1:0] sum;   // Raw ADD/SUB
  logic [alu_cpu_pkg::data_w-1:0] ea;    // LW/SW effective address
  logic [alu_cpu_pkg::data_w-1:0] padd;  // PADDSB lanes
  logic [2*alu_cpu_pkg::data_w-1:0] rot;
  logic       is_sub;
  logic       is_as;     // ADD or SUB
  logic       b_sign;    // Sign of the effective addend
  logic       pos_ov;
  logic       neg_ov;
  logic       invalid;
  logic [8:0] red_hi;    // Signed byte sums
  logic [8:0] red_lo;
  logic [9:0] red_tot;

  //////////////////////////////////////////////////////////////////////
  // ADD/SUB with saturation
  //////////////////////////////////////////////////////////////////////
  assign is_sub = (op == alu_cpu_pkg::op_sub);
  assign is_as  = (op == alu_cpu_pkg::op_add) | is_sub;
  assign sum    = is_sub ? in_a - in_b : in_a + in_b;
  assign b_sign = is_sub ? ~in_b[15] : in_b[15];
  assign pos_ov = is_as & ~in_a[15] & ~b_sign & sum[15];   // Two positives went negative
  assign neg_ov = is_as & in_a[15] & b_sign & ~sum[15];    // Two negatives went positive

  // Word aligned base plus word offset, never saturates
  assign ea = (in_a & 16'hFFFE) + {in_b[14:0], 1'b0};

  // RED: byte sums, then sum of sums
  assign red_hi  = {in_a[15], in_a[15:8]} + {in_b[15], in_b[15:8]};
  assign red_lo  = {in_a[7], in_a[7:0]} + {in_b[7], in_b[7:0]};
  assign red_tot = {red_hi[8], red_hi} + {red_lo[8], red_lo};

  assign rot = {in_a, in_a} >> in_b[3:0];  // Rotate right via doubled word

  // Four nibble lanes, each saturating to +7/-8
  always_comb begin
    logic [4:0] lane;
    for (int k = 0; k < 4; k++) begin
      lane = {in_a[4*k+3], in_a[4*k +: 4]} + {in_b[4*k+3], in_b[4*k +: 4]};
      if (lane[4] != lane[3]) begin
        padd[4*k +: 4] = lane[4] ? 4'h8 : 4'h7;
      end else begin
        padd[4*k +: 4] = lane[3:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    res     = '0;
    invalid = 1'b0;
    case (op)
      alu_cpu_pkg::op_add,
      alu_cpu_pkg::op_sub:    res = pos_ov ? 16'h7FFF : (neg_ov ? 16'h8000 : sum);
      alu_cpu_pkg::op_xor:    res = in_a ^ in_b;
      alu_cpu_pkg::op_red:    res = {{6{red_tot[9]}}, red_tot};
      alu_cpu_pkg::op_sll:    res = in_a << in_b[3:0];
      alu_cpu_pkg::op_sra:    res = $signed(in_a) >>> in_b[3:0];
      alu_cpu_pkg::op_ror:    res = rot[15:0];
      alu_cpu_pkg::op_paddsb: res = padd;
      alu_cpu_pkg::op_lw,
      alu_cpu_pkg::op_sw:     res = ea;
      alu_cpu_pkg::op_llb:    res = {in_a[15:8], in_b[7:0]};  // Keep high byte
      alu_cpu_pkg::op_lhb:    res = {in_b[7:0], in_a[7:0]};   // Keep low byte
      default:                invalid = 1'b1;                 // C..F, result stays zero
    endcase
  end

  assign out.res     = res;
  assign out.flags.z = (res == '0);
  assign out.flags.v = pos_ov | neg_ov;
  assign out.flags.n = res[15];
  assign out.invalid = invalid;

  // Bad opcode never leaks a value into the result register
  inv_zero_a: assert final (!out.invalid || out.res == '0)
    else $error("alu_core: invalid opcode with nonzero result");

endmodule

`default_nettype wire

//--- alu_cpu_pkg.sv
/*
 * Shared definitions for the AXI4-Lite ALU execution unit
 * Widths, opcode enum, instruction union, flag and result structs
 * AXI4-Lite request/response structs, register map, response codes
 */
`default_nettype none

package alu_cpu_pkg;

  localparam int data_w  = 16;  // ALU word width
  localparam int reg_cnt = 16;  // Register file depth
  localparam int axil_aw = 8;   // AXI address width
  localparam int axil_dw = 32;  // AXI data width

  //////////////////////////////////////////////////////////////////////
  // Opcodes and instruction word
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    op_add    = 4'h0,
    op_sub    = 4'h1,
    op_xor    = 4'h2,
    op_red    = 4'h3,
    op_sll    = 4'h4,
    op_sra    = 4'h5,
    op_ror    = 4'h6,
    op_paddsb = 4'h7,
    op_lw     = 4'h8,  // Address only, no memory
    op_sw     = 4'h9,
    op_llb    = 4'hA,
    op_lhb    = 4'hB   // C..F invalid
  } alu_op_e;

  typedef struct packed {
    alu_op_e    opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;  // imm4 for shifts and LW/SW
  } instr_r_t;

  typedef struct packed {
    alu_op_e    opcode;
    logic [3:0] rd;
    logic [7:0] imm8;  // LLB/LHB byte
  } instr_i_t;

  // Same 16 bits, two views
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } alu_flags_t;

  typedef struct packed {
    logic [data_w-1:0] res;
    alu_flags_t        flags;    // Candidates, flag reg picks
    logic              invalid;  // Opcode C..F
  } alu_out_t;

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [axil_aw-1:0] aw_addr;
    logic               aw_valid;
    logic [axil_dw-1:0] w_data;   // No strobes, whole words only
    logic               w_valid;
    logic               b_ready;
    logic [axil_aw-1:0] ar_addr;
    logic               ar_valid;
    logic               r_ready;
  } axil_req_t;

  typedef struct packed {
    logic               aw_ready;
    logic               w_ready;
    logic               b_valid;
    logic [1:0]         b_resp;
    logic               ar_ready;
    logic               r_valid;
    logic [axil_dw-1:0] r_data;
    logic [1:0]         r_resp;
  } axil_rsp_t;

  // Register map
  localparam logic [axil_aw-1:0] addr_instr    = 8'h00;
  localparam logic [axil_aw-1:0] addr_result   = 8'h04;
  localparam logic [axil_aw-1:0] addr_flags    = 8'h08;
  localparam logic [axil_aw-1:0] addr_status   = 8'h0C;
  localparam logic [axil_aw-1:0] addr_reg_base = 8'h40;  // reg i at +4*i

  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

endpackage

`default_nettype wire

//--- alu_exec.f
alu_cpu_pkg.sv
alu_regfile.sv
alu_flag_reg.sv
alu_core.sv
alu_exec_ctrl.sv
alu_exec_top.sv
tb_alu_exec.sv

//--- alu_exec_ctrl.sv
/*
 * AXI4-Lite slave and execute control
 * Instruction register and decode, operand select, execute pulse
 * Result and status registers, host read mux
 */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  alu_cpu_pkg::axil_req_t         req,
  output alu_cpu_pkg::axil_rsp_t         rsp,
  output logic [3:0]                     ra_addr,
  output logic [3:0]                     rb_addr,
  output logic [3:0]                     rc_addr,
  input  logic [alu_cpu_pkg::data_w-1:0] ra_data,
  input  logic [alu_cpu_pkg::data_w-1:0] rb_data,
  input  logic [alu_cpu_pkg::data_w-1:0] rc_data,
  output logic                           we,
  output logic [3:0]                     wa_addr,
  output logic [alu_cpu_pkg::data_w-1:0] wa_data,
  output alu_cpu_pkg::alu_op_e           op,
  output logic [alu_cpu_pkg::data_w-1:0] in_a,
  output logic [alu_cpu_pkg::data_w-1:0] in_b,
  input  alu_cpu_pkg::alu_out_t          alu_res,
  output logic                           flag_en,
  input  alu_cpu_pkg::alu_flags_t        flags
);

  alu_cpu_pkg::instr_u instr_q;  // Held instruction word
  logic       wr_rdy;            // AW and W ready together
  logic       wr_hs;
  logic       wr_pend;           // Response due on next edge
  logic       wr_instr;          // Accepted write hit addr_instr
  logic       exec;
  logic       is_lb;
  logic       b_valid;
  logic [1:0] b_resp;
  logic       ar_rdy;
  logic       rd_hs;
  logic       rd_pend;           // Data captured on next edge
  logic       r_valid;
  logic [1:0] r_resp;
  logic [alu_cpu_pkg::axil_aw-1:0] ar_addr_q;
  logic [alu_cpu_pkg::axil_dw-1:0] r_data;
  logic [alu_cpu_pkg::data_w-1:0]  rd_word;
  logic       rd_err;
  logic [alu_cpu_pkg::data_w-1:0]  result_q;
  logic       status_q;          // Status bit 0 marks last instruction invalid

  //////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////
  assign wr_hs = wr_rdy & req.aw_valid & req.w_valid;
  assign exec  = wr_pend & wr_instr;  // One cycle after acceptance

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_rdy  <= 1'b0;
      wr_pend <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      // One-cycle ready pulse only with nothing in flight
      wr_rdy  <= ~wr_rdy & req.aw_valid & req.w_valid & ~wr_pend
                 & ~(b_valid & ~req.b_ready);
      wr_pend <= wr_hs;
      if (wr_pend) begin
        b_valid <= 1'b1;
      end else if (req.b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      instr_q  <= req.w_data[alu_cpu_pkg::data_w-1:0];
      wr_instr <= (req.aw_addr == alu_cpu_pkg::addr_instr);  // Others ignored
    end
    if (wr_pend) begin
      b_resp <= (exec & alu_res.invalid) ? alu_cpu_pkg::resp_slverr : alu_cpu_pkg::resp_okay;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode and operands
  //////////////////////////////////////////////////////////////////////
  assign op      = instr_q.r.opcode;
  assign is_lb   = (op == alu_cpu_pkg::op_llb) | (op == alu_cpu_pkg::op_lhb);
  assign ra_addr = is_lb ? instr_q.i.rd : instr_q.r.rs;  // LLB/LHB merge into rd
  assign rb_addr = instr_q.r.rt;
  assign in_a    = ra_data;

  always_comb begin
    case (op)
      alu_cpu_pkg::op_sll,
      alu_cpu_pkg::op_sra,
      alu_cpu_pkg::op_ror: in_b = {12'b0, instr_q.r.rt};                    // Shift amount
      alu_cpu_pkg::op_lw,
      alu_cpu_pkg::op_sw:  in_b = {{12{instr_q.r.rt[3]}}, instr_q.r.rt};    // Signed offset
      alu_cpu_pkg::op_llb,
      alu_cpu_pkg::op_lhb: in_b = {8'b0, instr_q.i.imm8};
      default:             in_b = rb_data;
    endcase
  end

  // LW/SW produce an address only
  assign we      = exec & ~alu_res.invalid & (op != alu_cpu_pkg::op_lw)
                   & (op != alu_cpu_pkg::op_sw);
  assign wa_addr = instr_q.r.rd;
  assign wa_data = alu_res.res;
  assign flag_en = exec;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_q <= '0;
      status_q <= 1'b0;
    end else if (exec) begin
      result_q <= alu_res.res;
      status_q <= alu_res.invalid;  // Next valid op clears it
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////
  assign rd_hs   = ar_rdy & req.ar_valid;
  assign rc_addr = ar_addr_q[5:2];

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    if (ar_addr_q[7:6] == alu_cpu_pkg::addr_reg_base[7:6] && ar_addr_q[1:0] == 2'b00) begin
      rd_word = rc_data;
    end else begin
      case (ar_addr_q)
        alu_cpu_pkg::addr_result: rd_word = result_q;
        alu_cpu_pkg::addr_flags:  rd_word = {13'b0, flags};  // {z, v, n}
        alu_cpu_pkg::addr_status: rd_word = {15'b0, status_q};
        default:                  rd_err  = 1'b1;            // Unmapped address reads as zero
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_rdy  <= 1'b0;
      rd_pend <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      ar_rdy  <= ~rd_hs & ~rd_pend & ~(r_valid & ~req.r_ready);
      rd_pend <= rd_hs;
      if (rd_pend) begin
        r_valid <= 1'b1;
      end else if (req.r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Address taken at handshake and data one edge later so a same-edge execute is seen
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      ar_addr_q <= req.ar_addr;
    end
    if (rd_pend) begin
      r_data <= {16'b0, rd_word};
      r_resp <= rd_err ? alu_cpu_pkg::resp_slverr : alu_cpu_pkg::resp_okay;
    end
  end

  assign rsp.aw_ready = wr_rdy;
  assign rsp.w_ready  = wr_rdy;
  assign rsp.b_valid  = b_valid;
  assign rsp.b_resp   = b_resp;
  assign rsp.ar_ready = ar_rdy;
  assign rsp.r_valid  = r_valid;
  assign rsp.r_data   = r_data;
  assign rsp.r_resp   = r_resp;

  b_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.b_valid && !req.b_ready |=> rsp.b_valid && $stable(rsp.b_resp))
    else $error("alu_exec_ctrl: B response dropped before b_ready");

  we_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> (op <= alu_cpu_pkg::op_lhb))
    else $error("alu_exec_ctrl: register write on invalid opcode");

endmodule

`default_nettype wire

//--- alu_exec_top.sv
/*
 * ALU execution unit top
 * AXI control, register file, ALU core, flag register
 */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  alu_cpu_pkg::axil_req_t req,
  output alu_cpu_pkg::axil_rsp_t rsp
);

  logic [3:0]                     ra_addr;
  logic [3:0]                     rb_addr;
  logic [3:0]                     rc_addr;  // Host register read
  logic [alu_cpu_pkg::data_w-1:0] ra_data;
  logic [alu_cpu_pkg::data_w-1:0] rb_data;
  logic [alu_cpu_pkg::data_w-1:0] rc_data;
  logic                           we;
  logic [3:0]                     wa_addr;
  logic [alu_cpu_pkg::data_w-1:0] wa_data;
  alu_cpu_pkg::alu_op_e           op;
  logic [alu_cpu_pkg::data_w-1:0] in_a;
  logic [alu_cpu_pkg::data_w-1:0] in_b;
  alu_cpu_pkg::alu_out_t          alu_res;
  logic                           flag_en;
  alu_cpu_pkg::alu_flags_t        flags;

  alu_exec_ctrl u_ctrl (
    .clk, .rst_n, .req, .rsp,
    .ra_addr, .rb_addr, .rc_addr, .ra_data, .rb_data, .rc_data,
    .we, .wa_addr, .wa_data,
    .op, .in_a, .in_b, .alu_res,
    .flag_en, .flags
  );

  alu_regfile u_regfile (
    .clk, .rst_n,
    .ra_addr, .rb_addr, .rc_addr, .ra_data, .rb_data, .rc_data,
    .we, .wa_addr, .wa_data
  );

  alu_core u_core (.op, .in_a, .in_b, .out(alu_res));

  alu_flag_reg u_flags (.clk, .rst_n, .flag_en, .op, .cand(alu_res.flags), .flags);

endmodule

`default_nettype wire

//--- alu_flag_reg.sv
/*
 * Z/V/N flag register, update mask chosen by opcode class
 */
`timescale 1ns/1ps
`default_nettype none

module alu_flag_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flag_en,  // Execute cycle
  input  alu_cpu_pkg::alu_op_e    op,
  input  alu_cpu_pkg::alu_flags_t cand,
  output alu_cpu_pkg::alu_flags_t flags
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flag_en) begin
      case (op)
        alu_cpu_pkg::op_add,
        alu_cpu_pkg::op_sub: flags <= cand;      // Full update
        alu_cpu_pkg::op_xor,
        alu_cpu_pkg::op_sll,
        alu_cpu_pkg::op_sra,
        alu_cpu_pkg::op_ror: flags.z <= cand.z;  // Z only
        default: ;                               // RED, PADDSB, LW/SW, LLB/LHB, invalid
      endcase
    end
  end

  flags_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    !flag_en |=> $stable(flags))
    else $error("alu_flag_reg: flags moved without flag_en");

endmodule

`default_nettype wire

//--- alu_regfile.sv
/*
 * Sixteen-entry register file
 * Two operand read ports, one host read port, one write port
 */
`timescale 1ns/1ps
`default_nettype none

module alu_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [3:0]                     ra_addr,
  input  logic [3:0]                     rb_addr,
  input  logic [3:0]                     rc_addr,  // Host read
  output logic [alu_cpu_pkg::data_w-1:0] ra_data,
  output logic [alu_cpu_pkg::data_w-1:0] rb_data,
  output logic [alu_cpu_pkg::data_w-1:0] rc_data,
  input  logic                           we,
  input  logic [3:0]                     wa_addr,
  input  logic [alu_cpu_pkg::data_w-1:0] wa_data
);

  logic [alu_cpu_pkg::data_w-1:0] regs [alu_cpu_pkg::reg_cnt];  // R0 is ordinary

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < alu_cpu_pkg::reg_cnt; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa_addr] <= wa_data;
    end
  end

  // Combinational reads, old value during write cycle
  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr];
  assign rc_data = regs[rc_addr];

endmodule

`default_nettype wire

//--- tb_alu_exec.sv
/*
 * Testbench for the AXI4-Lite ALU execution unit
 * Clock, reset, AXI write/read tasks with random ready delays
 * Reference model of registers, flags, result and status, compare tasks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_exec;

  logic clk = 1'b0;
  logic rst_n;
  alu_cpu_pkg::axil_req_t req;
  alu_cpu_pkg::axil_rsp_t rsp;

  int seed;
  int err_cnt;                        // Wrong values
  int hs_cnt;                         // Handshake and protocol faults
  int wait_limit = 50;                // Cycles per wait loop
  logic [15:0] m_regs [16];           // Model state
  alu_cpu_pkg::alu_flags_t m_flags;
  logic [15:0] m_result;
  logic        m_status;
  logic [31:0] w;
  logic [31:0] v;
  logic [1:0]  r;
  logic [15:0] d;
  logic [3:0]  ls_ops [4] = '{4'h2, 4'h4, 4'h5, 4'h6};  // XOR and shifts

  alu_exec_top UUT (.clk, .rst_n, .req, .rsp);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input logic [alu_cpu_pkg::data_w-1:0] exp,
                            input logic [alu_cpu_pkg::data_w-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR @%0t %s: expected %h, got %h", $time, what, exp, act);
    end
  endtask

  task automatic check_flags(input alu_cpu_pkg::alu_flags_t exp,
                             input alu_cpu_pkg::alu_flags_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR @%0t flags zvn: expected %b, got %b", $time, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR @%0t %s resp: expected %0d, got %0d", $time, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    hs_cnt++;
    $display("Timeout: the %s handshake never completed", what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite host tasks, driven on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic axil_write(input logic [7:0] addr, input logic [15:0] data,
                            output logic [1:0] resp);
    int n;
    int dly;
    @(negedge clk);
    req.aw_addr  = addr;
    req.w_data   = {16'h0, data};
    req.aw_valid = 1'b1;
    req.w_valid  = 1'b1;
    n = 0;
    while (!(rsp.aw_ready && rsp.w_ready) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) report_timeout("AW/W");
    @(negedge clk);                   // Handshake edge just passed
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    n = 0;
    while (!rsp.b_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) report_timeout("B");
    else if (n != 1) begin
      hs_cnt++;
      $display("B response did not come two clocks after the write handshake");
    end
    resp = rsp.b_resp;
    dly  = $unsigned($random(seed)) % 6;  // Hold b_ready low a while
    repeat (dly) begin
      @(negedge clk);
      if (!rsp.b_valid || rsp.b_resp !== resp) begin
        hs_cnt++;
        $display("B response changed while b_ready was low");
      end
    end
    req.b_ready = 1'b1;
    @(negedge clk);
    req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [15:0] data,
                           output logic [1:0] resp);
    int n;
    int dly;
    @(negedge clk);
    req.ar_addr  = addr;
    req.ar_valid = 1'b1;
    n = 0;
    while (!rsp.ar_ready && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) report_timeout("AR");
    @(negedge clk);
    req.ar_valid = 1'b0;
    n = 0;
    while (!rsp.r_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (n == wait_limit) report_timeout("R");
    data = rsp.r_data[15:0];
    resp = rsp.r_resp;
    if (rsp.r_data[31:16] !== 16'h0) begin
      hs_cnt++;
      $display("Read data was not zero-extended");
    end
    dly = $unsigned($random(seed)) % 6;
    repeat (dly) begin
      @(negedge clk);
      if (!rsp.r_valid || rsp.r_data[15:0] !== data || rsp.r_resp !== resp) begin
        hs_cnt++;
        $display("R response changed while r_ready was low");
      end
    end
    req.r_ready = 1'b1;
    @(negedge clk);
    req.r_ready = 1'b0;
  endtask

  function automatic logic [7:0] reg_addr(input logic [3:0] idx);
    return alu_cpu_pkg::addr_reg_base + {2'b00, idx, 2'b00};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  task automatic model_exec(input logic [15:0] word, output logic [1:0] resp);
    alu_cpu_pkg::instr_u iw;
    logic [3:0]  opc;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    int sa;
    int sb;
    int s;
    int hi;
    int lo;
    iw   = word;
    opc  = iw.r.opcode;
    a    = m_regs[iw.r.rs];
    b    = m_regs[iw.r.rt];
    sa   = $signed(a);
    sb   = $signed(b);
    res  = '0;
    resp = alu_cpu_pkg::resp_okay;
    case (opc)
      4'h0, 4'h1: begin
        s = (opc == 4'h0) ? sa + sb : sa - sb;
        m_flags.v = (s > 32767) || (s < -32768);
        if (s > 32767) s = 32767;      // Clamp to the signed range
        else if (s < -32768) s = -32768;
        res = s[15:0];
        m_flags.n = res[15];
      end
      4'h2: res = a ^ b;
      4'h3: begin
        hi  = $signed(a[15:8]) + $signed(b[15:8]);
        lo  = $signed(a[7:0]) + $signed(b[7:0]);
        s   = hi + lo;
        res = s[15:0];
      end
      4'h4: res = a << iw.r.rt;
      4'h5: res = $signed(a) >>> iw.r.rt;
      4'h6: res = (a >> iw.r.rt) | (a << (16 - iw.r.rt));
      4'h7: begin
        for (int k = 0; k < 4; k++) begin
          s = $signed(a[4*k +: 4]) + $signed(b[4*k +: 4]);
          if (s > 7) s = 7;
          else if (s < -8) s = -8;
          res[4*k +: 4] = s[3:0];
        end
      end
      4'h8, 4'h9: begin
        s   = $signed(iw.r.rt);         // Word offset
        res = (a & 16'hFFFE) + s * 2;
      end
      4'hA: res = {m_regs[iw.i.rd][15:8], iw.i.imm8};
      4'hB: res = {iw.i.imm8, m_regs[iw.i.rd][7:0]};
      default: resp = alu_cpu_pkg::resp_slverr;
    endcase
    if (opc <= 4'h2 || (opc >= 4'h4 && opc <= 4'h6)) m_flags.z = (res == 16'h0);
    m_result = res;
    m_status = (opc >= 4'hC);
    if (opc < 4'h8 || opc == 4'hA || opc == 4'hB) m_regs[iw.r.rd] = res;
  endtask

  // Execute one instruction and compare all visible state it touches
  task automatic run_instr(input logic [15:0] word);
    logic [1:0]  exp_resp;
    logic [1:0]  resp;
    logic [15:0] data;
    model_exec(word, exp_resp);
    axil_write(alu_cpu_pkg::addr_instr, word, resp);
    check_resp("B", exp_resp, resp);
    axil_read(alu_cpu_pkg::addr_result, data, resp);
    check_word("result", m_result, data);
    axil_read(alu_cpu_pkg::addr_flags, data, resp);
    check_flags(m_flags, alu_cpu_pkg::alu_flags_t'(data[2:0]));
    axil_read(alu_cpu_pkg::addr_status, data, resp);
    check_word("status", {15'b0, m_status}, data);
    check_resp("status read", alu_cpu_pkg::resp_okay, resp);
    axil_read(reg_addr(word[11:8]), data, resp);
    check_word("rd", m_regs[word[11:8]], data);
  endtask

  task automatic load_reg(input logic [3:0] idx, input logic [15:0] val);
    run_instr({4'hA, idx, val[7:0]});
    run_instr({4'hB, idx, val[15:8]});
  endtask

  task automatic check_regs();
    logic [15:0] data;
    logic [1:0]  resp;
    for (int i = 0; i < 16; i++) begin
      axil_read(reg_addr(i[3:0]), data, resp);
      check_word($sformatf("R%0d", i), m_regs[i], data);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    req      = '0;
    rst_n    = 1'b0;
    seed     = 66692;
    err_cnt  = 0;
    hs_cnt   = 0;
    m_flags  = '0;
    m_result = '0;
    m_status = 1'b0;
    for (int i = 0; i < 16; i++) m_regs[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 16; i++) begin  // Byte loads into every register
      w = $random(seed);
      load_reg(i[3:0], w[15:0]);
    end
    check_regs();

    for (int k = 0; k < 30; k++) begin  // ADD/SUB with odd rounds near the limits
      w = $random(seed);
      v = $random(seed);
      if (k % 2) begin
        w[15:0] = {w[15], {7{~w[15]}}, w[7:0]};
        v[15:0] = {v[15], {7{~v[15]}}, v[7:0]};
      end
      load_reg(4'd1, w[15:0]);
      load_reg(4'd2, v[15:0]);
      run_instr({3'b000, w[20], v[19:16], 4'd1, 4'd2});
      run_instr({3'b000, w[21], w[27:16]});
    end

    load_reg(4'd1, 16'h7FFF);           // Saturating ADD sets V and clears N
    load_reg(4'd2, 16'h7FFF);
    run_instr({4'h0, 4'd5, 4'd1, 4'd2});

    for (int k = 0; k < 30; k++) begin  // Logic and shifts
      w = $random(seed);
      run_instr({ls_ops[w[17:16]], w[11:0]});
    end

    for (int k = 0; k < 30; k++) begin  // RED and PADDSB
      w = $random(seed);
      v = $random(seed);
      load_reg(4'd3, w[15:0]);
      load_reg(4'd4, v[15:0]);
      run_instr({w[16] ? 4'h7 : 4'h3, v[19:16], 4'd3, 4'd4});
    end

    for (int k = 0; k < 10; k++) begin  // LW/SW address only
      w = $random(seed);
      run_instr({3'b100, w[12], w[11:0]});
    end
    check_regs();
    for (int k = 0; k < 8; k++) begin   // Invalid opcodes each followed by a valid one
      w = $random(seed);
      run_instr({2'b11, w[13:0]});
      run_instr({4'h0, w[27:16]});
    end
    check_regs();

    axil_write(alu_cpu_pkg::addr_result, 16'hBEEF, r);  // Ignored write
    check_resp("ignored write", alu_cpu_pkg::resp_okay, r);
    axil_read(alu_cpu_pkg::addr_result, d, r);
    check_word("result after ignored write", m_result, d);
    axil_read(8'h10, d, r);                              // Unmapped
    check_word("unmapped data", 16'h0, d);
    check_resp("unmapped", alu_cpu_pkg::resp_slverr, r);
    check_regs();

    $display("Errors: %0d value, %0d handshake", err_cnt, hs_cnt);
    if (err_cnt == 0 && hs_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
